// ==== filelist.f ====
logic/alu_pkg.sv
logic/exec_if.sv
logic/reg_file.sv
logic/operand_fetch.sv
logic/alu_lane.sv
logic/lane_voter.sv
logic/redundant_alu_core.sv
test/tb_clock.sv
test/core_checker.sv
test/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_top
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_top.sv ====
/*
  Testbench for redundant_alu_core with five lanes.
  Each table row is one operation with its expected result, zero and lane_ok.
  Fault bits reach the lanes in the cycle after the operation is issued.
*/
module tb_top;

  localparam int LANES = 5;
  localparam int FAULT_W = $clog2(LANES);
  localparam int NUM_ROWS = 26;
  localparam int PERIOD = 10;
  localparam int RESET_CYCLES = 8;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 4 + RESET_CYCLES + 50;

  typedef struct {
    alu_pkg::alu_op_t   alu_op;
    alu_pkg::reg_addr_t ra1;
    alu_pkg::reg_addr_t ra2;
    alu_pkg::reg_addr_t wa;
    logic               write_en;
    logic               use_imm;
    alu_pkg::imm_t      imm;
    logic [FAULT_W-1:0] fault_lane;
    alu_pkg::word_t     fault_bits;
    int                 gap;
    alu_pkg::word_t     exp_result;
    logic               exp_zero;
    logic [LANES-1:0]   exp_lane_ok;
  } row_t;

  logic clk;
  logic reset;
  logic op_valid;
  alu_pkg::alu_op_t alu_op;
  alu_pkg::reg_addr_t ra1;
  alu_pkg::reg_addr_t ra2;
  alu_pkg::reg_addr_t wa;
  logic write_en;
  logic use_imm;
  alu_pkg::imm_t imm;
  logic [FAULT_W-1:0] fault_lane;
  alu_pkg::word_t fault_bits;
  logic result_valid;
  alu_pkg::word_t result;
  logic zero;
  logic [LANES-1:0] lane_ok;
  logic exp_push;
  alu_pkg::word_t exp_result;
  logic exp_zero;
  logic [LANES-1:0] exp_lane_ok;
  logic report;
  int pending;
  int error_count;
  row_t rows [NUM_ROWS];
  int row_count;
  logic [FAULT_W-1:0] staged_lane;
  alu_pkg::word_t staged_bits;

  tb_clock #(
    .PERIOD       (PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock (
    .clk   (clk),
    .reset (reset)
  );

  redundant_alu_core #(
    .LANES (LANES)
  ) uut (
    .clk          (clk),
    .reset        (reset),
    .op_valid     (op_valid),
    .alu_op       (alu_op),
    .ra1          (ra1),
    .ra2          (ra2),
    .wa           (wa),
    .write_en     (write_en),
    .use_imm      (use_imm),
    .imm          (imm),
    .fault_lane   (fault_lane),
    .fault_bits   (fault_bits),
    .result_valid (result_valid),
    .result       (result),
    .zero         (zero),
    .lane_ok      (lane_ok)
  );

  core_checker #(
    .LANES (LANES)
  ) u_checker (
    .clk          (clk),
    .exp_push     (exp_push),
    .exp_result   (exp_result),
    .exp_zero     (exp_zero),
    .exp_lane_ok  (exp_lane_ok),
    .result_valid (result_valid),
    .result       (result),
    .zero         (zero),
    .lane_ok      (lane_ok),
    .report       (report),
    .pending      (pending),
    .error_count  (error_count)
  );

  task automatic add_row(
    input alu_pkg::alu_op_t op,
    input int               src1,
    input int               src2,
    input int               dst,
    input int               we,
    input int               imm_sel,
    input int               imm_val,
    input int               lane,
    input alu_pkg::word_t   bits,
    input int               gap,
    input alu_pkg::word_t   want,
    input int               want_zero,
    input logic [LANES-1:0] want_ok
  );
    row_t r;
    r.alu_op = op;
    r.ra1 = alu_pkg::reg_addr_t'(src1);
    r.ra2 = alu_pkg::reg_addr_t'(src2);
    r.wa = alu_pkg::reg_addr_t'(dst);
    r.write_en = (we != 0);
    r.use_imm = (imm_sel != 0);
    r.imm = alu_pkg::imm_t'(imm_val);
    r.fault_lane = FAULT_W'(lane);
    r.fault_bits = bits;
    r.gap = gap;
    r.exp_result = want;
    r.exp_zero = (want_zero != 0);
    r.exp_lane_ok = want_ok;
    rows[row_count] = r;
    row_count++;
  endtask

  // Each row holds op, ra1, ra2, wa, write_en, use_imm, imm, fault lane, fault bits,
  // gap, expected result, expected zero and expected lane_ok.
  task automatic load_table();
    // Immediate loads into r1 to r5.
    add_row(alu_pkg::ALU_ADD, 0, 0, 1, 1, 1, 'h0005, 0, 32'h0, 0, 32'h00000005, 0, 5'b11111);
    add_row(alu_pkg::ALU_ADD, 0, 0, 2, 1, 1, 'hFFFD, 0, 32'h0, 0, 32'hFFFFFFFD, 0, 5'b11111);
    add_row(alu_pkg::ALU_ADD, 0, 0, 3, 1, 1, 'h00F0, 0, 32'h0, 0, 32'h000000F0, 0, 5'b11111);
    add_row(alu_pkg::ALU_ADD, 0, 0, 4, 1, 1, 'h8000, 0, 32'h0, 0, 32'hFFFF8000, 0, 5'b11111);
    add_row(alu_pkg::ALU_ADD, 0, 0, 5, 1, 1, 'h0005, 0, 32'h0, 1, 32'h00000005, 0, 5'b11111);
    // ALU functions on loaded registers.
    add_row(alu_pkg::ALU_AND, 3, 2, 6, 1, 0, 'h0, 0, 32'h0, 0, 32'h000000F0, 0, 5'b11111);
    add_row(alu_pkg::ALU_OR, 1, 3, 7, 1, 0, 'h0, 0, 32'h0, 0, 32'h000000F5, 0, 5'b11111);
    add_row(alu_pkg::ALU_ADD, 1, 2, 8, 1, 0, 'h0, 0, 32'h0, 0, 32'h00000002, 0, 5'b11111);
    add_row(alu_pkg::ALU_SUB, 1, 5, 9, 1, 0, 'h0, 0, 32'h0, 0, 32'h00000000, 1, 5'b11111);
    add_row(alu_pkg::ALU_SLT, 2, 1, 10, 1, 0, 'h0, 0, 32'h0, 0, 32'h00000001, 0, 5'b11111);
    add_row(alu_pkg::ALU_SLT, 1, 2, 11, 1, 0, 'h0, 0, 32'h0, 0, 32'h00000000, 1, 5'b11111);
    add_row(alu_pkg::ALU_ANDN, 2, 1, 12, 1, 0, 'h0, 0, 32'h0, 0, 32'hFFFFFFF8, 0, 5'b11111);
    add_row(alu_pkg::ALU_ORN, 3, 4, 13, 1, 0, 'h0, 0, 32'h0, 1, 32'h00007FFF, 0, 5'b11111);
    add_row(alu_pkg::ALU_SUB, 7, 6, 14, 1, 0, 'h0, 0, 32'h0, 1, 32'h00000005, 0, 5'b11111);
    add_row(alu_pkg::ALU_SUB, 14, 1, 15, 1, 0, 'h0, 0, 32'h0, 1, 32'h00000000, 1, 5'b11111);
    // Write to r0, then read it back.
    add_row(alu_pkg::ALU_ADD, 0, 0, 0, 1, 1, 'h1234, 0, 32'h0, 1, 32'h00001234, 0, 5'b11111);
    add_row(alu_pkg::ALU_OR, 0, 0, 16, 1, 0, 'h0, 0, 32'h0, 1, 32'h00000000, 1, 5'b11111);
    // Back to back with no hazards.
    add_row(alu_pkg::ALU_ADD, 1, 3, 17, 1, 0, 'h0, 0, 32'h0, 0, 32'h000000F5, 0, 5'b11111);
    add_row(alu_pkg::ALU_OR, 2, 4, 18, 1, 0, 'h0, 0, 32'h0, 0, 32'hFFFFFFFD, 0, 5'b11111);
    add_row(alu_pkg::ALU_AND, 4, 3, 19, 1, 0, 'h0, 0, 32'h0, 0, 32'h00000000, 1, 5'b11111);
    add_row(alu_pkg::ALU_SUB, 3, 1, 20, 1, 0, 'h0, 0, 32'h0, 1, 32'h000000EB, 0, 5'b11111);
    // Faults on lane 2 and then lane 4 are voted out.
    add_row(alu_pkg::ALU_ADD, 1, 5, 21, 1, 0, 'h0, 2, 32'h000000FF, 1,
            32'h0000000A, 0, 5'b11011);
    add_row(alu_pkg::ALU_AND, 3, 3, 22, 1, 0, 'h0, 0, 32'h0, 0, 32'h000000F0, 0, 5'b11011);
    add_row(alu_pkg::ALU_SUB, 2, 1, 23, 1, 0, 'h0, 4, 32'h80000001, 0,
            32'hFFFFFFF8, 0, 5'b01011);
    add_row(alu_pkg::ALU_ORN, 0, 0, 24, 1, 0, 'h0, 0, 32'h0, 0, 32'hFFFFFFFF, 0, 5'b01011);
    add_row(alu_pkg::ALU_ADD, 0, 0, 25, 1, 1, 'h7FFF, 2, 32'hFFFFFFFF, 0,
            32'h00007FFF, 0, 5'b01011);
  endtask

  // The fault of an operation is applied one cycle after its strobe.
  task automatic issue_cycle(input logic strobe, input row_t row);
    @(posedge clk);
    #1;
    fault_lane = staged_lane;
    fault_bits = staged_bits;
    op_valid = strobe;
    exp_push = strobe;
    if (strobe)
    begin
      alu_op = row.alu_op;
      ra1 = row.ra1;
      ra2 = row.ra2;
      wa = row.wa;
      write_en = row.write_en;
      use_imm = row.use_imm;
      imm = row.imm;
      exp_result = row.exp_result;
      exp_zero = row.exp_zero;
      exp_lane_ok = row.exp_lane_ok;
      staged_lane = row.fault_lane;
      staged_bits = row.fault_bits;
    end
    else
    begin
      staged_lane = '0;
      staged_bits = '0;
    end
  endtask

  initial
  begin
    op_valid = 1'b0;
    alu_op = alu_pkg::ALU_AND;
    ra1 = '0;
    ra2 = '0;
    wa = '0;
    write_en = 1'b0;
    use_imm = 1'b0;
    imm = '0;
    fault_lane = '0;
    fault_bits = '0;
    exp_push = 1'b0;
    exp_result = '0;
    exp_zero = 1'b0;
    exp_lane_ok = '0;
    report = 1'b0;
    staged_lane = '0;
    staged_bits = '0;
    row_count = 0;
    load_table();
    wait (reset == 1'b1);
    wait (reset == 1'b0);
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      issue_cycle(1'b1, rows[i]);
      for (int g = 0; g < rows[i].gap; g++)
      begin
        issue_cycle(1'b0, rows[i]);
      end
    end
    issue_cycle(1'b0, rows[0]);
    wait (pending == 0);
    repeat (4) @(posedge clk);
    #1;
    report = 1'b1;
    @(negedge clk);
    #1;
    if (error_count == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("Timeout after %0d cycles with %0d results outstanding", WATCHDOG_CYCLES, pending);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== test/core_checker.sv ====
/*
  Scoreboard for the execute unit. Expected rows are queued as operations issue
  and are matched in order against result_valid pulses.
  Compares on the falling edge, where the DUT outputs are stable.
*/
module core_checker #(
  parameter int LANES = 5
) (
  input  logic             clk,
  input  logic             exp_push,
  input  alu_pkg::word_t   exp_result,
  input  logic             exp_zero,
  input  logic [LANES-1:0] exp_lane_ok,
  input  logic             result_valid,
  input  alu_pkg::word_t   result,
  input  logic             zero,
  input  logic [LANES-1:0] lane_ok,
  input  logic             report,
  output int               pending,
  output int               error_count
);

  alu_pkg::word_t result_q [$];
  logic zero_q [$];
  logic [LANES-1:0] lane_ok_q [$];
  alu_pkg::word_t want_result;
  logic want_zero;
  logic [LANES-1:0] want_lane_ok;
  int row_errors;
  int tests_run;
  int tests_failed;
  int other_errors;
  logic reported = 1'b0;

  assign error_count = tests_failed + other_errors;

  always @(negedge clk)
  begin
    if (result_valid)
    begin
      if (result_q.size() == 0)
      begin
        $display("Unexpected result_valid at time %0t with no operation outstanding", $time);
        other_errors++;
      end
      else
      begin
        want_result = result_q.pop_front();
        want_zero = zero_q.pop_front();
        want_lane_ok = lane_ok_q.pop_front();
        row_errors = 0;
        if (result !== want_result)
        begin
          $display("MISMATCH at %0t: result expected %h got %h", $time, want_result, result);
          row_errors++;
        end
        if (zero !== want_zero)
        begin
          $display("MISMATCH at %0t: zero expected %b got %b", $time, want_zero, zero);
          row_errors++;
        end
        if (lane_ok !== want_lane_ok)
        begin
          $display("MISMATCH at %0t: lane_ok expected %b got %b", $time, want_lane_ok, lane_ok);
          row_errors++;
        end
        if (row_errors == 0)
        begin
          $display("test %0d passed, result %h lane_ok %b", tests_run, result, lane_ok);
        end
        else
        begin
          $display("test %0d failed with %0d wrong values", tests_run, row_errors);
          tests_failed++;
        end
        tests_run++;
      end
    end
    if (exp_push)
    begin
      result_q.push_back(exp_result);
      zero_q.push_back(exp_zero);
      lane_ok_q.push_back(exp_lane_ok);
    end
    pending = result_q.size();
    if (report && !reported)
    begin
      reported = 1'b1;
      if (pending != 0)
      begin
        $display("%0d expected results never arrived", pending);
        other_errors = other_errors + pending;
      end
      $display("tests run %0d, passed %0d, failed %0d, other errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, other_errors);
    end
  end

endmodule

// ==== test/tb_clock.sv ====
/*
  Clock and reset source for the testbench.
  Reset is asserted at time 0 and released 1 time unit after the last reset edge.
*/
module tb_clock #(
  parameter int PERIOD = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

// ==== logic/redundant_alu_core.sv ====
/*
  Execute unit with LANES voted ALU replicas, LANES odd and at least 3.
  Results appear two cycles after op_valid, in order, with no back-pressure.
  fault_bits corrupts lane fault_lane for self-test while it is nonzero.
*/
module redundant_alu_core #(
  parameter int LANES = 5
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       op_valid,
  input  alu_pkg::alu_op_t           alu_op,
  input  alu_pkg::reg_addr_t         ra1,
  input  alu_pkg::reg_addr_t         ra2,
  input  alu_pkg::reg_addr_t         wa,
  input  logic                       write_en,
  input  logic                       use_imm,
  input  alu_pkg::imm_t              imm,
  input  logic [$clog2(LANES)-1:0]   fault_lane,
  input  alu_pkg::word_t             fault_bits,
  output logic                       result_valid,
  output alu_pkg::word_t             result,
  output logic                       zero,
  output logic [LANES-1:0]           lane_ok
);

  alu_pkg::word_t rd1;
  alu_pkg::word_t rd2;
  logic wb_en;
  alu_pkg::reg_addr_t wb_addr;
  alu_pkg::word_t wb_data;
  alu_pkg::word_t [LANES-1:0] fault_mask;
  alu_pkg::word_t [LANES-1:0] lane_results;

  exec_if ex_bus ();

  reg_file u_reg_file (
    .clk     (clk),
    .ra1     (ra1),
    .ra2     (ra2),
    .rd1     (rd1),
    .rd2     (rd2),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  operand_fetch u_operand_fetch (
    .clk      (clk),
    .reset    (reset),
    .op_valid (op_valid),
    .use_imm  (use_imm),
    .write_en (write_en),
    .alu_op   (alu_op),
    .ra1      (ra1),
    .ra2      (ra2),
    .wa       (wa),
    .imm      (imm),
    .rd1      (rd1),
    .rd2      (rd2),
    .ex       (ex_bus)
  );

  for (genvar i = 0; i < LANES; i++)
  begin : g_lane
    // Only the selected lane sees the fault pattern.
    assign fault_mask[i] = (fault_lane == i) ? fault_bits : '0;

    alu_lane u_alu_lane (
      .ex          (ex_bus),
      .fault_mask  (fault_mask[i]),
      .lane_result (lane_results[i])
    );
  end

  lane_voter #(
    .LANES (LANES)
  ) u_lane_voter (
    .clk          (clk),
    .reset        (reset),
    .ex           (ex_bus),
    .lane_results (lane_results),
    .result       (result),
    .zero         (zero),
    .result_valid (result_valid),
    .lane_ok      (lane_ok),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data)
  );

endmodule

// ==== logic/lane_voter.sv ====
/*
  Bitwise majority over the enabled lanes, registered one cycle after issue.
  A tie among an even number of enabled lanes votes 0.
  A lane that disagrees with the vote is excluded until reset.
*/
module lane_voter #(
  parameter int LANES = 5
) (
  input  logic                             clk,
  input  logic                             reset,
  exec_if.sink                             ex,
  input  alu_pkg::word_t [LANES-1:0]       lane_results,
  output alu_pkg::word_t                   result,
  output logic                             zero,
  output logic                             result_valid,
  output logic [LANES-1:0]                 lane_ok,
  output logic                             wb_en,
  output alu_pkg::reg_addr_t               wb_addr,
  output alu_pkg::word_t                   wb_data
);

  // Wide enough to hold twice the lane count.
  localparam int CW = $clog2(LANES + 1) + 1;

  logic [CW-1:0] en_count;
  alu_pkg::word_t voted;
  logic [LANES-1:0] drop;

  always_comb
  begin : vote
    logic [CW-1:0] ones;
    en_count = '0;
    for (int i = 0; i < LANES; i++)
    begin
      en_count = en_count + CW'(lane_ok[i]);
    end
    for (int bit_idx = 0; bit_idx < alu_pkg::XLEN; bit_idx++)
    begin
      ones = '0;
      for (int i = 0; i < LANES; i++)
      begin
        ones = ones + CW'(lane_ok[i] & lane_results[i][bit_idx]);
      end
      // Strictly more than half of the enabled lanes.
      voted[bit_idx] = (ones << 1) > en_count;
    end
  end

  always_comb
  begin
    for (int i = 0; i < LANES; i++)
    begin
      drop[i] = lane_ok[i] && (lane_results[i] != voted);
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      result_valid <= 1'b0;
      lane_ok <= '1;
    end
    else
    begin
      result_valid <= ex.valid;
      if (ex.valid)
      begin
        lane_ok <= lane_ok & ~drop;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (ex.valid)
    begin
      result <= voted;
      zero <= (voted == '0);
    end
  end

  // Write back lands on the same edge as the output register.
  assign wb_en = ex.valid && ex.write_en;
  assign wb_addr = ex.wa;
  assign wb_data = voted;

  a_lane_ok_sticky: assert property (
    @(posedge clk) disable iff (reset)
    (lane_ok & ~$past(lane_ok)) == '0
  );

  // At least one lane must survive, or the vote means nothing.
  a_lane_ok_nonempty: assert property (
    @(posedge clk) disable iff (reset)
    lane_ok != '0
  );

endmodule

// ==== logic/alu_lane.sv ====
/*
  One ALU replica, purely combinational.
  fault_mask is XORed into the result and is zero in normal operation.
*/
module alu_lane (
  exec_if.lane           ex,
  input  alu_pkg::word_t fault_mask,
  output alu_pkg::word_t lane_result
);

  alu_pkg::word_t b_inv;
  alu_pkg::word_t sum;
  alu_pkg::word_t raw;

  // Bit 2 inverts b and adds one, giving a - b.
  assign b_inv = ex.alu_op[2] ? ~ex.b : ex.b;
  assign sum = ex.a + b_inv + alu_pkg::word_t'(ex.alu_op[2]);

  always_comb
  begin
    case (ex.alu_op[1:0])
      2'b00: raw = ex.a & b_inv;
      2'b01: raw = ex.a | b_inv;
      2'b10: raw = sum;
      default: raw = {{(alu_pkg::XLEN - 1){1'b0}}, sum[alu_pkg::XLEN-1]};
    endcase
  end

  assign lane_result = raw ^ fault_mask;

endmodule

// ==== logic/operand_fetch.sv ====
/*
  Selects the operands and registers one operation per op_valid strobe.
  There is no forwarding: an operation must not read a register written
  by the operation accepted in the cycle right before it.
*/
module operand_fetch (
  input  logic               clk,
  input  logic               reset,
  input  logic               op_valid,
  input  logic               use_imm,
  input  logic               write_en,
  input  alu_pkg::alu_op_t   alu_op,
  input  alu_pkg::reg_addr_t ra1,
  input  alu_pkg::reg_addr_t ra2,
  input  alu_pkg::reg_addr_t wa,
  input  alu_pkg::imm_t      imm,
  input  alu_pkg::word_t     rd1,
  input  alu_pkg::word_t     rd2,
  exec_if.source             ex
);

  alu_pkg::word_t imm_ext;
  alu_pkg::word_t b_sel;

  // Sign extend the immediate.
  assign imm_ext = {{(alu_pkg::XLEN - 16){imm[15]}}, imm};
  assign b_sel = use_imm ? imm_ext : rd2;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ex.valid <= 1'b0;
    end
    else
    begin
      ex.valid <= op_valid;
    end
  end

  // Payload only moves on an accepted strobe.
  always_ff @(posedge clk)
  begin
    if (op_valid)
    begin
      ex.a <= rd1;
      ex.b <= b_sel;
      ex.alu_op <= alu_op;
      ex.wa <= wa;
      ex.write_en <= write_en;
    end
  end

  // The operation in flight writes back at this edge, so its target
  // is still stale for the operation being accepted now.
  a_no_raw_hazard: assert property (
    @(posedge clk) disable iff (reset)
    (op_valid && ex.valid && ex.write_en && ex.wa != '0)
      |-> (ra1 != ex.wa) && (use_imm || ra2 != ex.wa)
  );

endmodule

// ==== logic/reg_file.sv ====
/*
  Register file with two combinational read ports and one write port.
  Register 0 always reads zero, contents are not cleared by reset.
  A write is visible to reads only after the rising edge.
*/
module reg_file (
  input  logic               clk,
  input  alu_pkg::reg_addr_t ra1,
  input  alu_pkg::reg_addr_t ra2,
  output alu_pkg::word_t     rd1,
  output alu_pkg::word_t     rd2,
  input  logic               wb_en,
  input  alu_pkg::reg_addr_t wb_addr,
  input  alu_pkg::word_t     wb_data
);

  alu_pkg::word_t regs [alu_pkg::REG_COUNT];

  always_ff @(posedge clk)
  begin
    if (wb_en)
    begin
      regs[wb_addr] <= wb_data;
    end
  end

  // Register 0 is hard wired to zero.
  assign rd1 = (ra1 != '0) ? regs[ra1] : '0;
  assign rd2 = (ra2 != '0) ? regs[ra2] : '0;

endmodule

// ==== logic/exec_if.sv ====
/*
  One accepted operation, from operand fetch to the ALU lanes and the voter.
  Valid is high for exactly one cycle per operation.
*/
interface exec_if;

  logic valid;
  alu_pkg::word_t a;
  alu_pkg::word_t b;
  alu_pkg::alu_op_t alu_op;
  alu_pkg::reg_addr_t wa;
  logic write_en;

  modport source (
    output valid,
    output a,
    output b,
    output alu_op,
    output wa,
    output write_en
  );

  // Lanes see only the operands and the function.
  modport lane (
    input a,
    input b,
    input alu_op
  );

  modport sink (
    input valid,
    input wa,
    input write_en
  );

endinterface

// ==== logic/alu_pkg.sv ====
/*
  Shared widths, vector types and ALU control codes for the redundant execute unit.
  Control bit 2 inverts operand b and supplies the carry-in.
  Bits 1:0 select AND, OR, sum or set-less-than.
*/
package alu_pkg;

  // Data word width and register count.
  localparam int XLEN = 32;
  localparam int REG_COUNT = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
  typedef logic [15:0] imm_t;

  // ALU control codes.
  typedef enum logic [2:0] {
    ALU_AND      = 3'b000,
    ALU_OR       = 3'b001,
    ALU_ADD      = 3'b010,
    ALU_SLTU_RAW = 3'b011,
    ALU_ANDN     = 3'b100,
    ALU_ORN      = 3'b101,
    ALU_SUB      = 3'b110,
    ALU_SLT      = 3'b111
  } alu_op_t;

  // ALU_SLTU_RAW gives the sign of a plus b, with no inversion of b.
  // ALU_SLT is the signed compare by the sign of a minus b, overflow ignored.

endpackage
